/* multiboot_ctrl.f */
src/multiboot_pkg.sv
src/boot_image_map.sv
src/icap_port_reg.sv
src/icap_sequencer.sv
src/multiboot_ctrl.sv
test/icap_model.sv
test/tb_multiboot_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the multiboot controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f multiboot_ctrl.f --top-module tb_multiboot_ctrl -o tb_multiboot_ctrl
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/tb_multiboot_ctrl > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "RESULT: FAIL" "$log"; then
   exit 1
fi
exit 0

/* src/boot_image_map.sv */
`timescale 1ns/10ps

module boot_image_map
  (
   input  multiboot_pkg::design_num_t design_num,
   output multiboot_pkg::word_t       gen1_word,
   output multiboot_pkg::word_t       gen2_word
   );

   import multiboot_pkg::*;

   // GENERAL_1 holds the low address half, GENERAL_2 the high half
   always_comb
   begin
      case (design_num) inside
         5'd16:
         begin
            gen1_word = 16'h0000;   // Golden image
            gen2_word = 16'h0000;
         end
         5'd1:
         begin
            gen1_word = 16'h8000;
            gen2_word = 16'h030A;
         end
         5'd2:
         begin
            gen1_word = 16'hC000;
            gen2_word = 16'h030F;
         end
         5'd3:
         begin
            gen1_word = 16'h0000;
            gen2_word = 16'h0315;
         end
         5'd4:
         begin
            gen1_word = 16'h4000;
            gen2_word = 16'h031A;
         end
         5'd7:
         begin
            gen1_word = 16'h0000;
            gen2_word = 16'h032A;
         end
         [5'd8:5'd11]:
         begin
            gen1_word = 16'h8000;
            gen2_word = 16'h031F;
         end
         [5'd12:5'd15]:
         begin
            gen1_word = 16'hC000;
            gen2_word = 16'h0324;
         end
         default:
         begin
            gen1_word = 16'h4000;   // Design 0 and unused numbers
            gen2_word = 16'h0305;
         end
      endcase
   end

endmodule

/* src/icap_port_reg.sv */
`timescale 1ns/10ps

module icap_port_reg
  (
   input  logic                     clk_16M00,
   input  logic                     rst_n,
   input  multiboot_pkg::icap_req_t  req,
   output multiboot_pkg::icap_rsp_t  rsp,
   output multiboot_pkg::icap_port_t icap_out,
   input  multiboot_pkg::icap_rsp_t  icap_in
   );

   import multiboot_pkg::*;

   always_ff @(posedge clk_16M00)
   begin
      if (!rst_n)
      begin
         icap_out.ce_n    <= 1'b1;       // Port disabled
         icap_out.write_n <= 1'b1;
         icap_out.din     <= cfg_null;
      end
      else
      begin
         icap_out.ce_n    <= req.ce_n;
         icap_out.write_n <= req.write_n;
         icap_out.din     <= byte_reverse(req.din);
      end
   end

   assign rsp.busy = icap_in.busy;
   assign rsp.dout = byte_reverse(icap_in.dout);   // Back to natural order

   a_port_off_after_reset: assert property (@(posedge clk_16M00)
      !rst_n |=> icap_out.ce_n);

endmodule

/* src/icap_sequencer.sv */
`timescale 1ns/10ps

module icap_sequencer
  (
   input  logic                      clk_16M00,
   input  logic                      rst_n,
   input  multiboot_pkg::design_num_t design_num,
   input  logic                      reconfigure,
   input  logic                      powerup,
   input  multiboot_pkg::sw_t         sw_in,
   input  multiboot_pkg::word_t       gen1_word,
   input  multiboot_pkg::word_t       gen2_word,
   input  multiboot_pkg::icap_rsp_t   rsp,
   output multiboot_pkg::icap_req_t   req,
   output multiboot_pkg::sw_t         sw_out,
   output multiboot_pkg::sw_t         pwr_out,
   output logic                      initialized
   );

   import multiboot_pkg::*;

   seq_state_t state;
   seq_state_t next_state;
   logic [3:0] startup_cnt;
   logic [7:0] soft_dip;        // {pwr, sw} read back from GENERAL_5
   gen5_u      rd_word;
   gen5_u      wr_word;

   assign rd_word.raw = rsp.dout;

   always_comb
   begin
      wr_word.fields.rsvd = 8'h00;
      wr_word.fields.pwr  = powerup ? sw_in : soft_dip[7:4];
      wr_word.fields.sw   = powerup ? sw_in : design_num[3:0];
   end

   assign sw_out      = powerup ? sw_in : soft_dip[3:0];
   assign pwr_out     = powerup ? sw_in : soft_dip[7:4];
   assign initialized = (state == idle);

   // ------------------------------
   // Next state
   // ------------------------------
   always_comb
   begin
      next_state = state.next();    // Most states simply advance
      case (state)
         rd_latch_data:
            if (rsp.busy)
               next_state = rd_latch_data;
         rd_noop_7:  next_state = idle;
         idle:       next_state = reconfigure ? dummy_1 : idle;
         rbt_noop_3: next_state = idle;
         default:    ;
      endcase
   end

   // ------------------------------
   // Request word per state
   // ------------------------------
   always_comb
   begin
      req.ce_n    = 1'b0;
      req.write_n = 1'b0;
      case (state)
         rd_dummy, dummy_2:         req.din = cfg_sync_h;
         rd_sync_h, sync_h:         req.din = cfg_sync_l;
         rd_noop_2:                 req.din = cfg_rd_gen5;
         rd_avoid_abort_4, gen5_l:  req.din = cfg_wr_cmd;
         rd_desync_h:               req.din = cfg_cmd_desync;
         sync_l:                    req.din = cfg_wr_gen1;
         gen1_h:                    req.din = gen1_word;
         gen1_l:                    req.din = cfg_wr_gen2;
         gen2_h:                    req.din = gen2_word;
         gen2_l:                    req.din = cfg_wr_gen5;
         gen5_h:                    req.din = wr_word.raw;
         rbt_h:                     req.din = cfg_cmd_reboot;
         init, rd_noop_6, rd_avoid_abort_1, rd_avoid_abort_2, rd_latch_data,
         rd_avoid_abort_3, idle, dummy_1, rbt_noop_3:
                                    req.din = cfg_null;
         default:                   req.din = cfg_noop;
      endcase

      // Toggle enable around the direction change so the read is not aborted
      case (state)
         rd_noop_6:        {req.ce_n, req.write_n} = 2'b10;
         rd_avoid_abort_1: {req.ce_n, req.write_n} = 2'b11;
         rd_avoid_abort_2: {req.ce_n, req.write_n} = 2'b01;
         rd_latch_data:    {req.ce_n, req.write_n} = rsp.busy ? 2'b01 : 2'b11;
         rd_avoid_abort_3: {req.ce_n, req.write_n} = 2'b10;
         default:          ;
      endcase
   end

   // ------------------------------
   // State, startup delay, soft switches
   // ------------------------------
   always_ff @(posedge clk_16M00)
   begin
      if (!rst_n)
      begin
         state       <= init;
         startup_cnt <= 4'd0;
         soft_dip    <= 8'h00;
      end
      else
      begin
         if (startup_cnt == startup_cycles)
         begin
            state <= next_state;
         end
         else
         begin
            startup_cnt <= startup_cnt + 4'd1;   // Hold init until the delay ends
            state       <= init;
         end
         if (state == rd_latch_data && !rsp.busy)
            soft_dip <= {rd_word.fields.pwr, rd_word.fields.sw};
      end
   end

   a_state_legal: assert property (@(posedge clk_16M00) disable iff (!rst_n)
      state inside {[init:rbt_noop_3]});

   // Readback cannot finish inside the startup delay
   a_init_delay: assert property (@(posedge clk_16M00) disable iff (!rst_n)
      $rose(rst_n) |-> !initialized [*15]);

endmodule

/* src/multiboot_ctrl.sv */
`timescale 1ns/10ps

module multiboot_ctrl
  (
   input  logic                      clk_16M00,
   input  logic                      rst_n,
   input  multiboot_pkg::design_num_t design_num,
   input  logic                      reconfigure,
   input  logic                      powerup,
   input  multiboot_pkg::sw_t         sw_in,
   output multiboot_pkg::sw_t         sw_out,
   output multiboot_pkg::sw_t         pwr_out,
   output logic                      initialized,
   output multiboot_pkg::icap_port_t  icap_out,
   input  multiboot_pkg::icap_rsp_t   icap_in
   );

   import multiboot_pkg::*;

   icap_req_t req;
   icap_rsp_t rsp;
   word_t     gen1_word;
   word_t     gen2_word;

   icap_sequencer i_icap_sequencer
     (
      .clk_16M00   (clk_16M00),
      .rst_n       (rst_n),
      .design_num  (design_num),
      .reconfigure (reconfigure),
      .powerup     (powerup),
      .sw_in       (sw_in),
      .gen1_word   (gen1_word),
      .gen2_word   (gen2_word),
      .rsp         (rsp),
      .req         (req),
      .sw_out      (sw_out),
      .pwr_out     (pwr_out),
      .initialized (initialized)
      );

   boot_image_map i_boot_image_map
     (
      .design_num (design_num),
      .gen1_word  (gen1_word),
      .gen2_word  (gen2_word)
      );

   icap_port_reg i_icap_port_reg
     (
      .clk_16M00 (clk_16M00),
      .rst_n     (rst_n),
      .req       (req),
      .rsp       (rsp),
      .icap_out  (icap_out),
      .icap_in   (icap_in)
      );

endmodule

/* src/multiboot_pkg.sv */
package multiboot_pkg;

   typedef logic [15:0] word_t;
   typedef logic [4:0]  design_num_t;
   typedef logic [3:0]  sw_t;

   // ------------------------------
   // Configuration words
   // ------------------------------
   localparam word_t cfg_null       = 16'hFFFF;
   localparam word_t cfg_sync_h     = 16'hAA99;
   localparam word_t cfg_sync_l     = 16'h5566;
   localparam word_t cfg_noop       = 16'h2000;
   localparam word_t cfg_rd_gen5    = 16'h2AE1;   // Type 1 read of GENERAL_5
   localparam word_t cfg_wr_gen1    = 16'h3261;
   localparam word_t cfg_wr_gen2    = 16'h3281;
   localparam word_t cfg_wr_gen5    = 16'h32E1;
   localparam word_t cfg_wr_cmd     = 16'h30A1;
   localparam word_t cfg_cmd_desync = 16'h000D;
   localparam word_t cfg_cmd_reboot = 16'h000E;

   localparam logic [3:0] startup_cycles = 4'd15;

   // ------------------------------
   // ICAP port
   // ------------------------------
   typedef struct packed {
      logic  ce_n;      // Active low enable
      logic  write_n;   // Low for write, high for read
      word_t din;
   } icap_req_t;

   typedef struct packed {
      logic  ce_n;
      logic  write_n;
      word_t din;       // Byte-wise bit reversed
   } icap_port_t;

   typedef struct packed {
      logic  busy;
      word_t dout;
   } icap_rsp_t;

   typedef union packed {
      word_t raw;
      struct packed {
         logic [7:0] rsvd;
         sw_t        pwr;
         sw_t        sw;
      } fields;
   } gen5_u;

   typedef enum logic [5:0] {
      init,
      rd_dummy, rd_sync_h, rd_sync_l, rd_noop_1, rd_noop_2, rd_gen5,
      rd_noop_3, rd_noop_4, rd_noop_5, rd_noop_6,
      rd_avoid_abort_1, rd_avoid_abort_2, rd_latch_data,
      rd_avoid_abort_3, rd_avoid_abort_4,
      rd_desync_h, rd_desync_l, rd_noop_7,
      idle,
      dummy_1, dummy_2, sync_h, sync_l,
      gen1_h, gen1_l, gen2_h, gen2_l, gen5_h, gen5_l,
      rbt_h, rbt_l, rbt_noop_0, rbt_noop_1, rbt_noop_2, rbt_noop_3
   } seq_state_t;

   // ICAP samples D0 first, so each byte is mirrored in place
   function automatic word_t byte_reverse(word_t w);
      word_t r;
      for (int i = 0; i < 8; i++)
      begin
         r[i]     = w[7 - i];
         r[8 + i] = w[15 - i];
      end
      return r;
   endfunction

endpackage

/* test/icap_model.sv */
`timescale 1ns/10ps

module icap_model
  (
   input  logic                      clk_16M00,
   input  logic                      rst_n,
   input  multiboot_pkg::icap_port_t  icap_out,
   output multiboot_pkg::icap_rsp_t   icap_in,
   input  multiboot_pkg::word_t       gen5_value,
   input  int                        busy_len,
   output logic                      wr_valid,
   output multiboot_pkg::word_t       wr_word,
   output int                        rb_count,
   output int                        errors
   );

   import multiboot_pkg::*;

   word_t rb_seq[$] = '{cfg_sync_h, cfg_sync_l, cfg_noop, cfg_noop, cfg_rd_gen5, cfg_noop,
      cfg_noop, cfg_noop, cfg_noop, cfg_wr_cmd, cfg_cmd_desync, cfg_noop, cfg_noop};

   int    wait_cnt;
   logic  rd_seen;
   logic  served;
   logic  wr_en;
   logic  rd_en;
   word_t word;

   function automatic word_t flip_bytes(word_t w);
      logic [7:0] hi;
      logic [7:0] lo;
      hi = {<<{w[15:8]}};
      lo = {<<{w[7:0]}};
      return {hi, lo};
   endfunction

   assign wr_en = !icap_out.ce_n && !icap_out.write_n;
   assign rd_en = !icap_out.ce_n && icap_out.write_n;
   assign word  = flip_bytes(icap_out.din);   // Pin order back to natural order

   initial
      icap_in <= '{busy: 1'b1, dout: 16'h0000};

   always @(posedge clk_16M00)
   begin
      wr_valid <= 1'b0;
      if (!rst_n)
      begin
         icap_in  <= '{busy: 1'b1, dout: 16'h0000};
         rd_seen  <= 1'b0;
         served   <= 1'b0;
         wait_cnt <= 0;
         rb_count <= 0;
      end
      else
      begin
         if (wr_en && word != cfg_null)
         begin
            wr_valid <= 1'b1;
            wr_word  <= word;
            if (rb_count < 13)
            begin
               assert (word == rb_seq[rb_count]) else
               begin
                  errors++;
                  $display("Error %0d ns: readback word %0d is %h, expected %h",
                     $time, rb_count, word, rb_seq[rb_count]);
               end
               rb_count <= rb_count + 1;
            end
         end
         if (rd_seen && !served)
            assert (!wr_en) else
            begin
               errors++;
               $display("Error %0d ns: write %h while the read is busy", $time, word);
            end

         // ------------------------------
         // GENERAL_5 read with busy period
         // ------------------------------
         if (rd_en && !served)
         begin
            if (!rd_seen)
               assert (rb_count == 9) else
               begin
                  errors++;
                  $display("Error %0d ns: read starts after %0d words, expected 9",
                     $time, rb_count);
               end
            rd_seen <= 1'b1;
            if (wait_cnt == busy_len)
            begin
               icap_in.busy <= 1'b0;
               icap_in.dout <= flip_bytes(gen5_value);
               served       <= 1'b1;
            end
            else
               wait_cnt <= wait_cnt + 1;
         end
         if (served && icap_out.ce_n == 1'b1)
            icap_in.busy <= 1'b1;   // Read finished
      end
   end

endmodule

/* test/tb_multiboot_ctrl.sv */
`timescale 1ns/10ps

module tb_multiboot_ctrl;

   import multiboot_pkg::*;

   logic        clk_16M00;
   logic        rst_n;
   design_num_t design_num;
   logic        reconfigure;
   logic        powerup;
   sw_t         sw_in;
   sw_t         sw_out;
   sw_t         pwr_out;
   logic        initialized;
   icap_port_t  icap_out;
   icap_rsp_t   icap_in;
   word_t       gen5_value;
   int          busy_len;
   logic        wr_valid;
   word_t       wr_word;
   int          rb_count;
   int          model_errors;
   int          errors;
   int          timeouts;
   word_t       wr_log[$];

   multiboot_ctrl i_multiboot_ctrl (.*);

   icap_model i_icap_model (.*, .errors(model_errors));

   initial
   begin
      clk_16M00 = 1'b0;
      forever
         #10 clk_16M00 = ~clk_16M00;
   end

   always @(posedge clk_16M00)
      if (wr_valid)
         wr_log.push_back(wr_word);

   task automatic log_error(input string msg);
      errors++;
      $display("Error %0d ns: %s", $time, msg);
   endtask

   task automatic wait_level(input logic level, input int limit, output int cycles);
      cycles = 0;
      while (initialized !== level && cycles < limit)
      begin
         @(negedge clk_16M00);
         cycles++;
      end
      if (initialized !== level)
      begin
         timeouts++;
         $display("Timeout: initialized did not go to %0b within %0d cycles", level, limit);
      end
   endtask

   // GENERAL_1 in the upper half, GENERAL_2 in the lower
   function automatic logic [31:0] boot_pair(design_num_t num);
      case (num)
         5'd16:   return 32'h0000_0000;   // Golden image
         5'd0:    return 32'h4000_0305;
         5'd1:    return 32'h8000_030A;
         5'd2:    return 32'hC000_030F;
         5'd3:    return 32'h0000_0315;
         5'd4:    return 32'h4000_031A;
         5'd7:    return 32'h0000_032A;
         5'd8, 5'd9, 5'd10, 5'd11:   return 32'h8000_031F;
         5'd12, 5'd13, 5'd14, 5'd15: return 32'hC000_0324;
         default: return 32'h4000_0305;
      endcase
   endfunction

   // ------------------------------
   // Reset, readback, switch outputs
   // ------------------------------
   task automatic readback_round(input int len, input logic pwr);
      int cycles;
      busy_len   = len;
      gen5_value = 16'($urandom);
      powerup    = pwr;
      sw_in      = 4'($urandom);
      rst_n      = 1'b0;
      repeat (3) @(negedge clk_16M00);
      assert (icap_out.ce_n === 1'b1 && initialized === 1'b0) else
         log_error($sformatf("ce_n %b initialized %b in reset", icap_out.ce_n, initialized));
      rst_n = 1'b1;
      wait_level(1'b1, 200, cycles);
      assert (cycles > 15) else
         log_error($sformatf("initialized rose after %0d cycles", cycles));
      repeat (3) @(negedge clk_16M00);   // Let the last readback words drain
      assert (rb_count == 13) else
         log_error($sformatf("%0d readback words, expected 13", rb_count));
      for (int i = 0; i < 4; i++)
      begin
         assert (sw_out == (pwr ? sw_in : gen5_value[3:0])
                 && pwr_out == (pwr ? sw_in : gen5_value[7:4])) else
            log_error($sformatf("sw_out %h pwr_out %h, sw_in %h GENERAL_5 %h",
               sw_out, pwr_out, sw_in, gen5_value));
         sw_in = 4'($urandom);
         @(negedge clk_16M00);
      end
   endtask

   task automatic reboot_round(input design_num_t num, input logic pwr);
      logic [31:0] pair;
      gen5_u       g5;
      word_t       want[$];
      int          cycles;
      design_num    = num;
      powerup       = pwr;
      sw_in         = 4'($urandom);
      pair          = boot_pair(num);
      g5.raw        = 16'h0000;
      g5.fields.pwr = pwr ? sw_in : gen5_value[7:4];
      g5.fields.sw  = pwr ? sw_in : num[3:0];
      want = '{cfg_sync_h, cfg_sync_l, cfg_wr_gen1, pair[31:16], cfg_wr_gen2, pair[15:0],
               cfg_wr_gen5, g5.raw, cfg_wr_cmd, cfg_cmd_reboot,
               cfg_noop, cfg_noop, cfg_noop, cfg_noop};
      wr_log.delete();
      reconfigure = 1'b1;
      @(negedge clk_16M00);
      reconfigure = 1'b0;
      wait_level(1'b0, 5, cycles);
      wait_level(1'b1, 40, cycles);
      repeat (3) @(negedge clk_16M00);
      assert (wr_log.size() == want.size()) else
         log_error($sformatf("design %0d: %0d reboot words, expected %0d",
            num, wr_log.size(), want.size()));
      for (int i = 0; i < want.size() && i < wr_log.size(); i++)
         assert (wr_log[i] == want[i]) else
            log_error($sformatf("design %0d: reboot word %0d is %h, expected %h",
               num, i, wr_log[i], want[i]));
   endtask

   initial
   begin
      rst_n       = 1'b0;
      design_num  = 5'd0;
      reconfigure = 1'b0;
      powerup     = 1'b0;
      sw_in       = 4'h0;
      gen5_value  = 16'h0000;
      busy_len    = 0;
      errors      = 0;
      timeouts    = 0;
      void'($urandom(32'h6f5));
      for (int r = 0; r < 4; r++)
         readback_round((r == 0) ? 0 : int'($urandom_range(0, 6)), 1'b0);
      readback_round(int'($urandom_range(0, 6)), 1'b1);
      for (int n = 0; n <= 16; n++)
         reboot_round(5'(n), 1'b0);   // Every table row once
      for (int r = 0; r < 10; r++)
         reboot_round(5'($urandom_range(0, 31)), r[0]);

      $display("Errors: %0d check, %0d model, %0d timeout", errors, model_errors, timeouts);
      if (errors == 0 && model_errors == 0 && timeouts == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule
